/* hdl/exe_isa_pkg.sv */
`default_nettype none

package exe_isa_pkg;

    // modeled subset only, no far or packed forms
    typedef enum logic [3:0] {
        OP_ADD   = 4'd0,
        OP_AND   = 4'd1,
        OP_OR    = 4'd2,
        OP_NOT   = 4'd3,
        OP_SAL   = 4'd4,
        OP_SAR   = 4'd5,
        OP_MOV   = 4'd6,
        OP_XCHG  = 4'd7,
        OP_CMOVC = 4'd8,
        OP_JMP   = 4'd9,   // near, absolute target in op1
        OP_JCC   = 4'd10,
        OP_CLD   = 4'd11,
        OP_STD   = 4'd12,
        OP_NOP   = 4'd13
    } exe_op_e;

    typedef enum logic [1:0] {
        COND_C  = 2'd0,    // jump on CF
        COND_Z  = 2'd1,    // jump on ZF
        COND_NC = 2'd2,
        COND_NZ = 2'd3
    } exe_cond_e;

    typedef logic [11:0] eflags_t;  // low 12 bits of x86 EFLAGS

    localparam int FLAG_CF = 0;
    localparam int FLAG_PF = 2;
    localparam int FLAG_AF = 4;
    localparam int FLAG_ZF = 6;
    localparam int FLAG_SF = 7;
    localparam int FLAG_DF = 10;
    localparam int FLAG_OF = 11;

    // status flags written by arithmetic, logic and shift ops
    localparam eflags_t FLAGS_ARITH = 12'b1000_1101_0101;

endpackage

`default_nettype wire

/* hdl/exe_uop_pkg.sv */
`default_nettype none

package exe_uop_pkg;

    // one decoded micro-op as seen by execute
    typedef struct packed {
        exe_isa_pkg::exe_op_e   op;
        logic [31:0]            op1;
        logic [31:0]            op2;
        logic [31:0]            eip;          // address of this instruction
        exe_isa_pkg::exe_cond_e cond;         // only meaningful for JCC
        logic [31:0]            pred_target;  // from fetch predictor
        logic                   pred_taken;
    } exe_uop_t;

    // registered result toward writeback
    typedef struct packed {
        logic [31:0] res1;
        logic [31:0] res2;
        logic        res1_wb;
        logic        res2_wb;
        logic        br_valid;
        logic        br_taken;
        logic        br_correct;   // prediction matched
        logic [31:0] br_target;
    } exe_result_t;

    // writeback buffer slots
    localparam int CREDIT_DEPTH = 4;

    // counter must hold 0..CREDIT_DEPTH
    localparam int CREDIT_W = 3;

endpackage

`default_nettype wire

/* hdl/exe_flags_if.sv */
`default_nettype none

interface exe_flags_if;
    import exe_isa_pkg::*;

    eflags_t new_flags;    // alu proposal
    logic    shift_zero;   // shift count was zero, flags untouched
    eflags_t cur_flags;    // architectural state
    logic    commit;       // uop accepted and not skipped

    modport alu (output new_flags, output shift_zero, input cur_flags);

    modport regs (input new_flags, input shift_zero, input commit, output cur_flags);

    modport reader (input cur_flags);

    // output stage owns the commit strobe
    modport commit_drv (output commit);

endinterface

`default_nettype wire

/* hdl/exe_alu.sv */
`default_nettype none

module exe_alu (
    input  exe_uop_pkg::exe_uop_t uop,
    exe_flags_if.alu              flags,
    output logic [31:0]           res1,
    output logic [31:0]           res2,
    output logic                  res1_wb,
    output logic                  res2_wb
);
    import exe_isa_pkg::*;

    logic [32:0] sum;       // bit 32 is carry out
    logic [32:0] sal_w;     // bit 32 holds last bit out on the left
    logic [32:0] sar_w;     // bit 0 holds last bit out on the right
    logic [4:0]  cnt;
    logic        is_shift;
    logic        logic_flags;  // result based ZF/SF/PF apply

    assign cnt      = uop.op2[4:0];    // x86 masks count to 5 bits
    assign sum      = {1'b0, uop.op1} + {1'b0, uop.op2};
    assign sal_w    = {1'b0, uop.op1} << cnt;
    assign sar_w    = $signed({uop.op1, 1'b0}) >>> cnt;   // sign fill
    assign is_shift = (uop.op == OP_SAL) || (uop.op == OP_SAR);

    assign flags.shift_zero = is_shift && (cnt == 5'd0);

    always_comb begin
        res1            = '0;
        res2            = '0;
        res1_wb         = 1'b0;
        res2_wb         = 1'b0;
        logic_flags     = 1'b0;
        flags.new_flags = flags.cur_flags;  // ops without flags echo state
        case (uop.op)
            OP_ADD: begin
                res1    = sum[31:0];
                res1_wb = 1'b1;
                logic_flags = 1'b1;
                flags.new_flags[FLAG_CF] = sum[32];
                flags.new_flags[FLAG_AF] = uop.op1[4] ^ uop.op2[4] ^ sum[4];  // carry into bit 4
                // same sign in, other sign out
                flags.new_flags[FLAG_OF] = (uop.op1[31] == uop.op2[31]) && (sum[31] != uop.op1[31]);
            end
            OP_AND, OP_OR: begin
                res1    = (uop.op == OP_AND) ? (uop.op1 & uop.op2) : (uop.op1 | uop.op2);
                res1_wb = 1'b1;
                logic_flags = 1'b1;
                flags.new_flags[FLAG_CF] = 1'b0;
                flags.new_flags[FLAG_AF] = 1'b0;
                flags.new_flags[FLAG_OF] = 1'b0;
            end
            OP_NOT: begin
                res1    = ~uop.op1;
                res1_wb = 1'b1;
            end
            OP_SAL, OP_SAR: begin
                res1    = (uop.op == OP_SAL) ? sal_w[31:0] : sar_w[32:1];
                res1_wb = 1'b1;
                logic_flags = 1'b1;
                flags.new_flags[FLAG_CF] = (uop.op == OP_SAL) ? sal_w[32] : sar_w[0];
                flags.new_flags[FLAG_AF] = 1'b0;
                flags.new_flags[FLAG_OF] = 1'b0;   // simplified, not x86 count-1 rule
            end
            OP_MOV, OP_CMOVC: begin
                res1    = uop.op2;   // cmovc skip decided in branch block
                res1_wb = 1'b1;
            end
            OP_XCHG: begin
                res1    = uop.op2;
                res2    = uop.op1;
                res1_wb = 1'b1;
                res2_wb = 1'b1;
            end
            default: ;   // jumps, cld, std, nop write no register
        endcase
        if (logic_flags) begin
            flags.new_flags[FLAG_ZF] = (res1 == 32'd0);
            flags.new_flags[FLAG_SF] = res1[31];
            flags.new_flags[FLAG_PF] = ~^res1[7:0];  // even parity of low byte
        end
    end

endmodule

`default_nettype wire

/* hdl/exe_eflags.sv */
`default_nettype none

module exe_eflags (
    input logic                 clk,
    input logic                 reset,
    input exe_isa_pkg::exe_op_e op,
    exe_flags_if.regs           flags
);
    import exe_isa_pkg::*;

    eflags_t flags_q;
    eflags_t upd_mask;   // which bits this op may write
    eflags_t upd_val;

    // mask from opcode, cld/std patch DF directly
    always_comb begin
        upd_mask = '0;
        upd_val  = flags.new_flags;
        case (op)
            OP_ADD, OP_AND, OP_OR: upd_mask = FLAGS_ARITH;
            OP_SAL, OP_SAR:        upd_mask = flags.shift_zero ? '0 : FLAGS_ARITH;  // count 0 keeps all
            OP_CLD: begin
                upd_mask[FLAG_DF] = 1'b1;
                upd_val[FLAG_DF]  = 1'b0;
            end
            OP_STD: begin
                upd_mask[FLAG_DF] = 1'b1;
                upd_val[FLAG_DF]  = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flags_q <= '0;
        end else if (flags.commit) begin
            flags_q <= (flags_q & ~upd_mask) | (upd_val & upd_mask);  // same edge as accept
        end
    end

    assign flags.cur_flags = flags_q;

endmodule

`default_nettype wire

/* hdl/exe_branch_resolve.sv */
`default_nettype none

module exe_branch_resolve (
    input  exe_uop_pkg::exe_uop_t uop,
    exe_flags_if.reader           flags,
    output logic                  skip,
    output logic                  br_valid,
    output logic                  br_taken,
    output logic                  br_correct,
    output logic [31:0]           br_target
);
    import exe_isa_pkg::*;

    logic cond_hit;
    logic is_jmp;
    logic is_jcc;

    assign is_jmp = (uop.op == OP_JMP);
    assign is_jcc = (uop.op == OP_JCC);

    // condition evaluated on committed flags of the previous uop
    always_comb begin
        case (uop.cond)
            COND_C:  cond_hit = flags.cur_flags[FLAG_CF];
            COND_Z:  cond_hit = flags.cur_flags[FLAG_ZF];
            COND_NC: cond_hit = !flags.cur_flags[FLAG_CF];
            COND_NZ: cond_hit = !flags.cur_flags[FLAG_ZF];
            default: cond_hit = 1'b0;
        endcase
    end

    // cmovc drops its write when carry clear
    assign skip = (uop.op == OP_CMOVC) && !flags.cur_flags[FLAG_CF];

    assign br_valid  = is_jmp || is_jcc;
    assign br_taken  = is_jmp || (is_jcc && cond_hit);
    assign br_target = uop.op1;     // near target already absolute

    // not taken only needs the direction to agree
    assign br_correct = br_valid && (br_taken == uop.pred_taken) &&
                        (!br_taken || (uop.op1 == uop.pred_target));

endmodule

`default_nettype wire

/* hdl/exe_credit_out.sv */
`default_nettype none

module exe_credit_out (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic                     skip,
    input  exe_uop_pkg::exe_result_t next_res,
    input  logic                     credit_return,
    output logic                     out_valid,
    output exe_uop_pkg::exe_result_t out_res,
    exe_flags_if.commit_drv          flags
);
    import exe_uop_pkg::*;

    logic [CREDIT_W-1:0] credit_cnt;   // free writeback slots
    logic                accept;
    logic                send;         // accepted and produces a result

    assign in_ready    = (credit_cnt != '0);   // counter only
    assign accept      = in_valid && in_ready;
    assign send        = accept && !skip;
    assign flags.commit = send;   // skipped cmovc leaves flags alone

    always_ff @(posedge clk) begin
        if (reset) begin
            credit_cnt <= CREDIT_W'(CREDIT_DEPTH);
        end else if (send && !credit_return) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (credit_return && !send && (credit_cnt != CREDIT_W'(CREDIT_DEPTH))) begin
            credit_cnt <= credit_cnt + 1'b1;   // clamp at depth
        end
        // send and return together cancel out
    end

    // one cycle latency, pulse per delivered result
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_res   <= '0;   // clears write enables and br_valid
        end else begin
            out_valid <= send;
            if (send) begin
                out_res <= next_res;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/exe_stage_top.sv */
`default_nettype none

module exe_stage_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  exe_isa_pkg::exe_op_e   in_op,
    input  logic [31:0]            in_op1,
    input  logic [31:0]            in_op2,
    input  logic [31:0]            in_eip,
    input  exe_isa_pkg::exe_cond_e in_cond,
    input  logic [31:0]            in_pred_target,
    input  logic                   in_pred_taken,
    input  logic                   credit_return,
    output logic                   out_valid,
    output logic [31:0]            out_res1,
    output logic [31:0]            out_res2,
    output logic                   out_res1_wb,
    output logic                   out_res2_wb,
    output exe_isa_pkg::eflags_t   out_flags,
    output logic                   br_valid,
    output logic                   br_taken,
    output logic                   br_correct,
    output logic [31:0]            br_target
);
    import exe_isa_pkg::*;
    import exe_uop_pkg::*;

    exe_uop_t    uop;
    exe_result_t next_res;
    exe_result_t out_res;
    logic [31:0] alu_res1, alu_res2;
    logic        alu_res1_wb, alu_res2_wb;
    logic        skip;
    logic        bv, bt, bc;    // combinational branch outcome
    logic [31:0] btgt;

    exe_flags_if flags_bus ();

    assign uop = '{op: in_op, op1: in_op1, op2: in_op2, eip: in_eip, cond: in_cond,
                   pred_target: in_pred_target, pred_taken: in_pred_taken};

    exe_alu u_alu (.uop(uop), .flags(flags_bus), .res1(alu_res1), .res2(alu_res2),
                   .res1_wb(alu_res1_wb), .res2_wb(alu_res2_wb));

    exe_eflags u_eflags (.clk(clk), .reset(reset), .op(uop.op), .flags(flags_bus));

    exe_branch_resolve u_branch (.uop(uop), .flags(flags_bus), .skip(skip), .br_valid(bv),
                                 .br_taken(bt), .br_correct(bc), .br_target(btgt));

    assign next_res = '{res1: alu_res1, res2: alu_res2, res1_wb: alu_res1_wb,
                        res2_wb: alu_res2_wb, br_valid: bv, br_taken: bt,
                        br_correct: bc, br_target: btgt};

    exe_credit_out u_out (.clk(clk), .reset(reset), .in_valid(in_valid), .in_ready(in_ready),
                          .skip(skip), .next_res(next_res), .credit_return(credit_return),
                          .out_valid(out_valid), .out_res(out_res), .flags(flags_bus));

    assign out_res1    = out_res.res1;
    assign out_res2    = out_res.res2;
    assign out_res1_wb = out_res.res1_wb;
    assign out_res2_wb = out_res.res2_wb;
    assign br_valid    = out_res.br_valid;
    assign br_taken    = out_res.br_taken;
    assign br_correct  = out_res.br_correct;
    assign br_target   = out_res.br_target;
    assign out_flags   = flags_bus.cur_flags;   // already updated with the result

endmodule

`default_nettype wire

/* verif/exe_stage_properties.sv */
`default_nettype none

module exe_stage_properties (
    input logic                             clk,
    input logic                             reset,
    input logic                             out_valid,
    input logic [exe_uop_pkg::CREDIT_W-1:0] credit_cnt
);
    import exe_uop_pkg::*;

    // free slots never above buffer size
    property p_cnt_bound;
        @(posedge clk) disable iff (reset) credit_cnt <= CREDIT_W'(CREDIT_DEPTH);
    endproperty

    // a result needs a free slot when it was sent
    property p_send_needs_credit;
        @(posedge clk) disable iff (reset) out_valid |-> ($past(credit_cnt) != '0);
    endproperty

    property p_reset_quiet;
        @(posedge clk) reset |=> !out_valid;
    endproperty

    a_cnt_bound: assert property (p_cnt_bound) else $error("credit counter above depth");
    a_send_needs_credit: assert property (p_send_needs_credit)
        else $error("result sent with no free credit");
    a_reset_quiet: assert property (p_reset_quiet) else $error("out_valid high after reset");

endmodule

`default_nettype wire

/* verif/exe_stage_tb.sv */
`default_nettype none

module exe_stage_tb;
    import exe_isa_pkg::*;
    import exe_uop_pkg::*;

    localparam int CLK_PERIOD     = 8;
    localparam int CYCLES_PER_VEC = 40;
    localparam int NUM_FIELDS     = 18;   // columns per vector line

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    exe_op_e     in_op;
    logic [31:0] in_op1, in_op2, in_eip, in_pred_target;
    exe_cond_e   in_cond;
    logic        in_pred_taken;
    logic        credit_return;
    logic        out_valid;
    logic [31:0] out_res1, out_res2, br_target;
    logic        out_res1_wb, out_res2_wb;
    eflags_t     out_flags;
    logic        br_valid, br_taken, br_correct;

    string       vec_lines[$];     // data lines only
    string       cur_name;
    int          errors;
    int          results_seen;     // out_valid pulses so far
    int          returns_issued;
    int          exp_results;
    logic        withhold;         // writeback keeps slots until the buffer is full
    logic        saw_full;
    logic        loaded;
    logic [7:0]  lfsr;

    exe_stage_top dut (.*);

    bind exe_credit_out exe_stage_properties u_props (.clk(clk), .reset(reset),
        .out_valid(out_valid), .credit_cnt(credit_cnt));

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic check_result(input string name, input exe_result_t exp,
                                input exe_result_t act);
        if (act !== exp) begin
            errors++;
            $write("MISMATCH %s result: expected res1=%h res2=%h wb=%b%b br=%b%b%b tgt=%h,",
                   name, exp.res1, exp.res2, exp.res1_wb, exp.res2_wb, exp.br_valid,
                   exp.br_taken, exp.br_correct, exp.br_target);
            $display(" actual res1=%h res2=%h wb=%b%b br=%b%b%b tgt=%h", act.res1, act.res2,
                     act.res1_wb, act.res2_wb, act.br_valid, act.br_taken, act.br_correct,
                     act.br_target);
        end
    endtask

    task automatic check_flags(input string name, input eflags_t exp, input eflags_t act);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s flags: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input string what, input logic exp,
                             input logic act);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s %s: expected %b, actual %b", name, what, exp, act);
        end
    endtask

    // writeback model returns one slot when the lfsr bit says so
    always @(posedge clk) begin
        if (reset) begin
            credit_return <= 1'b0;
        end else if (!withhold && (results_seen > returns_issued)) begin
            lfsr = lfsr_step(lfsr);   // one step per bit taken
            credit_return <= lfsr[0];
            if (lfsr[0]) begin
                returns_issued++;
            end
        end else begin
            credit_return <= 1'b0;
        end
    end

    // credit accounting seen from outside and sampled mid cycle
    always @(negedge clk) begin
        int exp_credits;
        if (!reset) begin
            if (out_valid) begin
                results_seen++;
            end
            // a return driven this cycle lands on the next edge
            exp_credits = CREDIT_DEPTH - (results_seen - returns_issued) - int'(credit_return);
            check_bit(cur_name, "in_ready", exp_credits != 0, in_ready);
            if (withhold && !in_ready && (results_seen - returns_issued == CREDIT_DEPTH)) begin
                withhold = 1'b0;
                saw_full = 1'b1;
            end
        end
    end

    initial begin
        wait (loaded);
        #((vec_lines.size() + 1) * CYCLES_PER_VEC * CLK_PERIOD);
        $display("ERROR: run did not finish in time, DUT stalled or lost a result");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int          fd;
        int          err_before;
        int          passed;
        string       line;
        string       name;
        logic [31:0] f_op, op1, op2, eip, cond, ptgt, ptk, vld, r1, r2;
        logic [31:0] wb1, wb2, bv, bt, bc, tgt, flg;
        exe_result_t exp_res;
        exe_result_t act_res;
        reset          = 1'b1;
        in_valid       = 1'b0;
        in_op          = OP_NOP;
        in_op1         = '0;
        in_op2         = '0;
        in_eip         = '0;
        in_cond        = COND_C;
        in_pred_target = '0;
        in_pred_taken  = 1'b0;
        credit_return  = 1'b0;
        errors         = 0;
        results_seen   = 0;
        returns_issued = 0;
        exp_results    = 0;
        passed         = 0;
        withhold       = 1'b1;
        saw_full       = 1'b0;
        lfsr           = 8'd82;
        cur_name       = "reset";
        fd = $fopen("verif/exe_stage_vectors.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open verif/exe_stage_vectors.txt");
            errors++;
        end else begin
            while ($fgets(line, fd)) begin
                if (line.len() > 1 && line.substr(0, 0) != "#") begin
                    vec_lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        foreach (vec_lines[i]) begin
            if ($sscanf(vec_lines[i], "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        name, f_op, op1, op2, eip, cond, ptgt, ptk, vld, r1, r2, wb1, wb2,
                        bv, bt, bc, tgt, flg) != NUM_FIELDS) begin
                errors++;
                $display("ERROR: vector line %0d is malformed", i);
                continue;
            end
            exp_results += vld[0];
            @(posedge clk);
            cur_name   = name;
            err_before = errors;
            in_valid       <= 1'b1;
            in_op          <= exe_op_e'(f_op[3:0]);
            in_op1         <= op1;
            in_op2         <= op2;
            in_eip         <= eip;
            in_cond        <= exe_cond_e'(cond[1:0]);
            in_pred_target <= ptgt;
            in_pred_taken  <= ptk[0];
            @(negedge clk);
            while (!in_ready) @(negedge clk);   // held under back-pressure
            @(posedge clk);                      // accept edge
            in_valid <= 1'b0;
            @(negedge clk);
            check_bit(name, "out_valid", vld[0], out_valid);
            if (vld[0]) begin
                exp_res = '{res1: r1, res2: r2, res1_wb: wb1[0], res2_wb: wb2[0],
                            br_valid: bv[0], br_taken: bt[0], br_correct: bc[0],
                            br_target: tgt};
                act_res = '{res1: out_res1, res2: out_res2, res1_wb: out_res1_wb,
                            res2_wb: out_res2_wb, br_valid: br_valid, br_taken: br_taken,
                            br_correct: br_correct, br_target: br_target};
                check_result(name, exp_res, act_res);
            end
            check_flags(name, flg[11:0], out_flags);   // flags move on the accept edge
            if (errors == err_before) begin
                passed++;
                $display("PASS %s", name);
            end else begin
                $display("FAIL %s", name);
            end
        end
        @(posedge clk);
        cur_name = "drain";
        @(posedge clk);   // a late duplicate pulse is counted by now
        if (results_seen != exp_results) begin
            errors++;
            $display("ERROR: %0d results delivered but %0d expected", results_seen, exp_results);
        end
        if (!saw_full) begin
            errors++;
            $display("ERROR: in_ready never dropped with all credits outstanding");
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d", vec_lines.size(), passed,
                 vec_lines.size() - passed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/exe_stage_vectors.txt */
# name op op1 op2 eip cond pred_tgt pred_tk | valid res1 res2 wb1 wb2 brv brt brc br_tgt flags
# all hex, op and cond as enum codes, result fields ignored when valid is 0
add_cf  0 ffffffff 00000001 1000 0 00000000 0 1 00000000 00000000 1 0 0 0 0 ffffffff 055
cmovc_t 8 00000000 12345678 1004 0 00000000 0 1 12345678 00000000 1 0 0 0 0 00000000 055
and_clr 1 f0f0f0f0 0f0f0f0f 1008 0 00000000 0 1 00000000 00000000 1 0 0 0 0 f0f0f0f0 044
cmovc_s 8 00000000 87654321 100c 0 00000000 0 0 00000000 00000000 0 0 0 0 0 00000000 044
or_sf   2 80000000 00000001 1010 0 00000000 0 1 80000001 00000000 1 0 0 0 0 80000000 080
add_of  0 7fffffff 00000001 1014 0 00000000 0 1 80000000 00000000 1 0 0 0 0 7fffffff 894
not     3 0000ff00 00000000 1018 0 00000000 0 1 ffff00ff 00000000 1 0 0 0 0 0000ff00 894
sal     4 80000001 00000001 101c 0 00000000 0 1 00000002 00000000 1 0 0 0 0 80000001 001
sar     5 80000010 00000004 1020 0 00000000 0 1 f8000001 00000000 1 0 0 0 0 80000010 080
sal0    4 12345678 00000000 1024 0 00000000 0 1 12345678 00000000 1 0 0 0 0 12345678 080
mov     6 00000000 cafef00d 1028 0 00000000 0 1 cafef00d 00000000 1 0 0 0 0 00000000 080
xchg    7 11111111 22222222 102c 0 00000000 0 1 22222222 11111111 1 1 0 0 0 11111111 080
std     c 00000000 00000000 1030 0 00000000 0 1 00000000 00000000 0 0 0 0 0 00000000 480
jmp     9 00002000 00000000 1034 0 00002000 1 1 00000000 00000000 0 0 1 1 1 00002000 480
jcc_c   a 00003000 00000000 1038 0 00003000 0 1 00000000 00000000 0 0 1 0 1 00003000 480
jcc_z   a 00003100 00000000 103c 1 00003100 1 1 00000000 00000000 0 0 1 0 0 00003100 480
jcc_nc  a 00004000 00000000 1040 2 00004000 1 1 00000000 00000000 0 0 1 1 1 00004000 480
jcc_nz  a 00005000 00000000 1044 3 00005004 1 1 00000000 00000000 0 0 1 1 0 00005000 480
cld     b 00000000 00000000 1048 0 00000000 0 1 00000000 00000000 0 0 0 0 0 00000000 080

/* sim.f */
hdl/exe_isa_pkg.sv
hdl/exe_uop_pkg.sv
hdl/exe_flags_if.sv
hdl/exe_alu.sv
hdl/exe_eflags.sv
hdl/exe_branch_resolve.sv
hdl/exe_credit_out.sv
hdl/exe_stage_top.sv
verif/exe_stage_properties.sv
verif/exe_stage_tb.sv
